//--- sim.f
+incdir+design
design/capture_pkg.sv
design/sram_tile.sv
design/capture_trigger.sv
design/oneshot_multimemory.sv
design/capture_readout.sv
design/capture_top.sv
verification/tb_capture_top.sv

//--- Makefile
# Verilator build for the ADC snapshot capture testbench.
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_capture_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard design/*.sv design/*.svh verification/*.sv)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits non-zero when the testbench stops on $fatal.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_capture_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "capture_defines.svh"

module tb_capture_top;

    import capture_pkg::*;

    localparam int words       = 1 << `CAP_SYS_ADDR_BITS;
    localparam int last_addr   = words - 1;
    localparam int n_samples   = words * `CAP_LANES;
    localparam int read_cycles = 1 + (1 + `CAP_LANES) * words;

    // the lane pattern repeats after this many cycles.
    localparam int pattern_period = (1 << `CAP_ADC_BITS) / `CAP_LANES;

    // lane 0 of the running pattern is a multiple of 4 and never reaches this level.
    localparam adc_sample_t trig_level = adc_sample_t'(127);

    logic        clk;
    logic        rstb;
    adc_sample_t adc_in [`CAP_LANES-1:0];
    logic        arm;
    adc_sample_t threshold;
    logic        read_start;
    adc_sample_t sample_out;
    logic        sample_valid;
    logic        read_done;
    sys_addr_t   fill_addr;

    int     cycle;
    int     force_cycle;
    int     trig_a;
    integer seed;

    capture_top u_capture_top (
        .clk          (clk),
        .rstb         (rstb),
        .adc_in       (adc_in),
        .arm          (arm),
        .threshold    (threshold),
        .read_start   (read_start),
        .sample_out   (sample_out),
        .sample_valid (sample_valid),
        .read_done    (read_done),
        .fill_addr    (fill_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic adc_sample_t lane_pattern(input int c, input int j);
        return adc_sample_t'(c * `CAP_LANES + j);
    endfunction

    // sample n of a capture comes from cycle trig + n/lanes, lane n mod lanes.
    function automatic adc_sample_t expected_sample(input int trig_cycle, input int n);
        int c;
        int j;
        c = trig_cycle + n / `CAP_LANES;
        j = n % `CAP_LANES;
        if (c == trig_cycle && j == 0) begin
            return trig_level;
        end
        return lane_pattern(c, j);
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("ERROR at time %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    // one clock of stimulus, driven on the falling edge.
    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        for (int j = 0; j < `CAP_LANES; j++) begin
            adc_in[j] = lane_pattern(cycle, j);
        end
        if (cycle == force_cycle) begin
            adc_in[0] = trig_level; // forced crossing on lane 0.
        end
    endtask

    task automatic apply_reset();
        rstb = 1'b0;
        repeat (10) next_cycle();
        rstb = 1'b1;
        next_cycle();
        check_value(int'(fill_addr), 0, "fill_addr after reset");
        check_value(int'(sample_valid), 0, "sample_valid after reset");
        check_value(int'(read_done), 0, "read_done after reset");
    endtask

    // a negative prev_trig means there is no earlier capture in the memory.
    task automatic capture(input int prev_trig, output int trig_cycle);
        int delay;
        int waited;
        delay = 5 + int'({$random(seed)} % 40);
        // a whole pattern period after the previous trigger would store the same words.
        if (prev_trig >= 0 && (cycle + delay - prev_trig) % pattern_period == 0) begin
            delay++;
        end
        force_cycle = cycle + delay;
        trig_cycle  = force_cycle;
        waited      = 0;
        while (int'(fill_addr) != last_addr) begin
            if (waited == delay + 100) begin
                timeout_fail("fill_addr to reach the last address");
            end
            next_cycle();
            waited++;
        end
        // write_addr lands on the last address at edge k+65 and shows at the next falling edge.
        check_value(cycle - trig_cycle, last_addr + 3, "cycles from trigger to last address");
        repeat (2) next_cycle();
    endtask

    task automatic read_and_check(input int trig_cycle);
        int   elapsed;
        int   n;
        logic done;
        read_start = 1'b1;
        next_cycle();
        read_start = 1'b0;
        elapsed    = 0;
        n          = 0;
        done       = 1'b0;
        while (done == 1'b0) begin
            next_cycle();
            elapsed++;
            if (elapsed > read_cycles + 20) begin
                timeout_fail("read_done");
            end
            read_start = (elapsed == 100); // a start in mid sweep is ignored.
            if (sample_valid == 1'b1) begin
                check_value(sample_out, expected_sample(trig_cycle, n),
                            $sformatf("readout sample %0d", n));
                n++;
            end
            if (read_done == 1'b1) begin
                done = 1'b1;
            end
        end
        read_start = 1'b0;
        check_value(elapsed, read_cycles, "cycles from read_start to read_done");
        check_value(n, n_samples, "number of sample_valid cycles");
        next_cycle();
        check_value(int'(read_done), 0, "read_done held longer than one cycle");
    endtask

    task automatic disarmed_no_trigger();
        arm         = 1'b0;
        force_cycle = cycle + 3;
        for (int i = 0; i < 100; i++) begin
            next_cycle();
            check_value(int'(fill_addr), 0, "fill_addr moved while disarmed");
        end
    endtask

    task automatic armed_capture(output int trig_cycle);
        arm = 1'b1;
        repeat (3) next_cycle();
        capture(-1, trig_cycle);
        read_and_check(trig_cycle);
    endtask

    task automatic one_shot_hold(input int trig_cycle);
        force_cycle = cycle + 3;
        for (int i = 0; i < 80; i++) begin
            next_cycle();
            check_value(int'(fill_addr), last_addr, "fill_addr left the last address while armed");
        end
        read_and_check(trig_cycle);
    endtask

    task automatic rearm_capture(input int old_trig);
        int waited;
        int new_trig;
        arm    = 1'b0;
        waited = 0;
        while (int'(fill_addr) != 0) begin
            if (waited == 10) begin
                timeout_fail("fill_addr to return to 0 after disarm");
            end
            next_cycle();
            waited++;
        end
        next_cycle();
        arm = 1'b1;
        repeat (3) next_cycle();
        capture(old_trig, new_trig);
        read_and_check(new_trig);
    endtask

    initial begin
        rstb        = 1'b0;
        arm         = 1'b0;
        read_start  = 1'b0;
        threshold   = trig_level;
        for (int j = 0; j < `CAP_LANES; j++) begin
            adc_in[j] = '0;
        end
        cycle       = 0;
        force_cycle = -1;
        trig_a      = 0;
        seed        = 32'h42492b82;

        apply_reset();
        disarmed_no_trigger();
        armed_capture(trig_a);
        one_shot_hold(trig_a);
        rearm_capture(trig_a);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/capture_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "capture_defines.svh"

module capture_top (
    input wire logic                           clk,
    input wire logic                           rstb,
    input wire logic signed [`CAP_ADC_BITS-1:0] adc_in [`CAP_LANES-1:0],
    input wire logic                           arm,
    input wire logic signed [`CAP_ADC_BITS-1:0] threshold,
    input wire logic                           read_start,
    output logic signed [`CAP_ADC_BITS-1:0]     sample_out,
    output logic                               sample_valid,
    output logic                               read_done,
    output logic [`CAP_SYS_ADDR_BITS-1:0]       fill_addr
);

    logic signed [`CAP_ADC_BITS-1:0] lane_data [`CAP_LANES-1:0];
    logic                            start_write;
    logic [`CAP_SYS_ADDR_BITS-1:0]   read_addr;
    logic signed [`CAP_ADC_BITS-1:0] read_word_lanes [`CAP_LANES-1:0];

    capture_trigger u_trigger (
        .clk         (clk),
        .rstb        (rstb),
        .adc_in      (adc_in),
        .arm         (arm),
        .threshold   (threshold),
        .lane_data   (lane_data),
        .start_write (start_write)
    );

    oneshot_multimemory #(
        .n_tiles (`CAP_TILES)
    ) u_buffer (
        .clk            (clk),
        .rstb           (rstb),
        .in_bytes       (lane_data),
        .in_start_write (start_write),
        .in_addr        (read_addr),
        .out_data       (read_word_lanes),
        .addr           (fill_addr)
    );

    capture_readout u_readout (
        .clk          (clk),
        .rstb         (rstb),
        .read_start   (read_start),
        .read_addr    (read_addr),
        .word_lanes   (read_word_lanes),
        .sample_out   (sample_out),
        .sample_valid (sample_valid),
        .read_done    (read_done)
    );

endmodule

`default_nettype wire

//--- design/capture_readout.sv
`timescale 1ns/1ps
`default_nettype none
`include "capture_defines.svh"

module capture_readout (
    input wire logic                    clk,
    input wire logic                    rstb,
    input wire logic                    read_start,
    output capture_pkg::sys_addr_t       read_addr,
    input wire capture_pkg::adc_sample_t word_lanes [`CAP_LANES-1:0],
    output capture_pkg::adc_sample_t     sample_out,
    output logic                        sample_valid,
    output logic                        read_done
);

    import capture_pkg::*;

    localparam int unsigned lane_bits = $clog2(`CAP_LANES);
    localparam sys_addr_t   last_addr = '1;
    localparam logic [lane_bits-1:0] last_lane = lane_bits'(`CAP_LANES - 1);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_SHIFT,
        RD_FINISH
    } rd_state_t;

    rd_state_t          state;
    logic [lane_bits-1:0] lane;
    adc_sample_t        word_q [`CAP_LANES-1:0];

    always_ff @(posedge clk) begin
        if (rstb == 1'b0) begin
            state        <= RD_IDLE;
            read_addr    <= '0;
            lane         <= '0;
            sample_valid <= 1'b0;
            read_done    <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            read_done    <= 1'b0;
            case (state)
                RD_IDLE : begin
                    if (read_start == 1'b1) begin
                        read_addr <= '0;
                        state     <= RD_FETCH;
                    end
                end
                RD_FETCH : begin
                    lane  <= '0; // the tile registers q on this edge.
                    state <= RD_SHIFT;
                end
                RD_SHIFT : begin
                    sample_valid <= 1'b1;
                    if (lane == last_lane) begin
                        lane <= '0;
                        if (read_addr == last_addr) begin
                            state <= RD_FINISH;
                        end else begin
                            read_addr <= read_addr + 1'b1;
                            state     <= RD_FETCH;
                        end
                    end else begin
                        lane <= lane + 1'b1;
                    end
                end
                RD_FINISH : begin
                    read_done <= 1'b1;
                    state     <= RD_IDLE;
                end
                default : begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // Lane 0 comes straight from the memory while the word is latched for the rest.
    always_ff @(posedge clk) begin
        if (state == RD_SHIFT) begin
            if (lane == '0) begin
                word_q     <= word_lanes;
                sample_out <= word_lanes[0];
            end else begin
                sample_out <= word_q[lane];
            end
        end
    end

    a_valid_done_apart : assert property (
        @(posedge clk) disable iff (rstb == 1'b0)
        !(sample_valid && read_done)
    );

endmodule

`default_nettype wire

//--- design/oneshot_multimemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "capture_defines.svh"

module oneshot_multimemory #(
    parameter int unsigned n_tiles = `CAP_TILES
) (
    input wire logic                    clk,
    input wire logic                    rstb,
    input wire capture_pkg::adc_sample_t in_bytes [`CAP_LANES-1:0],
    input wire logic                    in_start_write,
    input wire capture_pkg::sys_addr_t   in_addr,
    output capture_pkg::adc_sample_t     out_data [`CAP_LANES-1:0],
    output capture_pkg::sys_addr_t       addr
);

    import capture_pkg::*;

    localparam int unsigned tile_bits = $bits(tile_addr_t);
    localparam int unsigned lane_bits = $bits(adc_sample_t);
    localparam int unsigned sel_bits  = (n_tiles > 1) ? $clog2(n_tiles) : 1;
    localparam sys_addr_t   max_addr  = sys_addr_t'((n_tiles << tile_bits) - 1);

    typedef logic [sel_bits-1:0] sel_t;

    typedef enum logic [1:0] {
        WAIT_FOR_WRITE,
        WRITING,
        WRITE_DONE
    } wr_state_t;

    wr_state_t  state;
    logic       web;
    sys_addr_t  write_addr;
    sys_addr_t  active_addr;
    tile_addr_t tile_addr;
    sel_t       tile_sel;
    sel_t       rd_sel;
    logic       ceb [n_tiles-1:0];
    mem_word_t  wr_word;
    mem_word_t  tile_q [n_tiles-1:0];

    always_ff @(posedge clk) begin
        if (rstb == 1'b0) begin
            state      <= WAIT_FOR_WRITE;
            web        <= 1'b1;
            write_addr <= '0;
        end else begin
            case (state)
                WAIT_FOR_WRITE : begin
                    write_addr <= '0;
                    if (in_start_write == 1'b1) begin
                        web   <= 1'b0;
                        state <= WRITING;
                    end
                end
                WRITING : begin
                    if (write_addr == max_addr) begin
                        web   <= 1'b1; // last word goes in on this edge.
                        state <= WRITE_DONE;
                    end else begin
                        write_addr <= write_addr + 1'b1;
                    end
                end
                WRITE_DONE : begin
                    // parked at max until the trigger drops start_write.
                    if (in_start_write == 1'b0) begin
                        write_addr <= '0;
                        state      <= WAIT_FOR_WRITE;
                    end
                end
                default : begin
                    web        <= 1'b1;
                    write_addr <= '0;
                    state      <= WAIT_FOR_WRITE;
                end
            endcase
        end
    end

    assign addr = write_addr;

    assign active_addr = (web == 1'b0) ? write_addr : in_addr;
    assign tile_addr   = tile_addr_t'(active_addr);
    assign tile_sel    = sel_t'(active_addr >> tile_bits);

    // Remember which tile was read so out_data follows the tile that drives q.
    always_ff @(posedge clk) begin
        rd_sel <= tile_sel;
    end

    for (genvar j = 0; j < `CAP_LANES; j++) begin : g_lane
        assign wr_word[j*lane_bits +: lane_bits] = in_bytes[j];
        assign out_data[j] = tile_q[rd_sel][j*lane_bits +: lane_bits];
    end

    for (genvar i = 0; i < n_tiles; i++) begin : g_tile
        assign ceb[i] = (tile_sel != sel_t'(i)); // one-hot select, active low.

        sram_tile u_tile (
            .clk (clk),
            .ceb (ceb[i]),
            .web (ceb[i] | web),
            .a   (tile_addr),
            .d   (wr_word),
            .q   (tile_q[i])
        );
    end

    a_we_only_writing : assert property (
        @(posedge clk) disable iff (rstb == 1'b0)
        (web == 1'b0) |-> (state == WRITING)
    );

    a_addr_in_range : assert property (
        @(posedge clk) disable iff (rstb == 1'b0)
        (state == WRITING) |-> (write_addr <= max_addr)
    );

endmodule

`default_nettype wire

//--- design/capture_trigger.sv
`timescale 1ns/1ps
`default_nettype none
`include "capture_defines.svh"

module capture_trigger (
    input wire logic                    clk,
    input wire logic                    rstb,
    input wire capture_pkg::adc_sample_t adc_in [`CAP_LANES-1:0],
    input wire logic                    arm,
    input wire capture_pkg::adc_sample_t threshold,
    output capture_pkg::adc_sample_t     lane_data [`CAP_LANES-1:0],
    output logic                        start_write
);

    import capture_pkg::*;

    // Three stages cover the compare register, the fired flag and the
    // buffer's enable, so the triggering sample lands on address 0.
    localparam int unsigned delay_stages = 3;

    adc_sample_t dly [delay_stages-1:0][`CAP_LANES-1:0];

    logic crossed;
    logic fired;

    always_ff @(posedge clk) begin
        dly[0] <= adc_in;
        for (int s = 1; s < delay_stages; s++) begin
            dly[s] <= dly[s-1];
        end
    end

    assign lane_data = dly[delay_stages-1];

    always_ff @(posedge clk) begin
        if (rstb == 1'b0) begin
            crossed <= 1'b0;
            fired   <= 1'b0;
        end else begin
            crossed <= arm && (adc_in[0] >= threshold); // both sides signed.
            if (arm == 1'b0) begin
                fired <= 1'b0;
            end else if (crossed == 1'b1) begin
                fired <= 1'b1;
            end
        end
    end

    // fired stays up for the rest of the arm period, which makes the capture one-shot.
    assign start_write = fired;

    a_no_start_disarmed : assert property (
        @(posedge clk) disable iff (rstb == 1'b0)
        $rose(start_write) |-> $past(arm)
    );

endmodule

`default_nettype wire

//--- design/sram_tile.sv
`timescale 1ns/1ps
`default_nettype none

module sram_tile (
    input wire logic                   clk,
    input wire logic                   ceb,
    input wire logic                   web,
    input wire capture_pkg::tile_addr_t a,
    input wire capture_pkg::mem_word_t  d,
    output capture_pkg::mem_word_t      q
);

    import capture_pkg::*;

    localparam int unsigned depth = 1 << $bits(tile_addr_t);

    mem_word_t mem [depth];

    // A write also drives q, so a read that lands during a capture sees the
    // word being written.
    always_ff @(posedge clk) begin
        if (ceb == 1'b0) begin
            if (web == 1'b0) begin
                mem[a] <= d;
                q      <= d;
            end else begin
                q <= mem[a]; // one cycle read latency.
            end
        end
    end

    a_addr_known : assert property (
        @(posedge clk) (ceb == 1'b0) |-> !$isunknown(a)
    );

endmodule

`default_nettype wire

//--- design/capture_pkg.sv
`include "capture_defines.svh"

package capture_pkg;

    // one signed sample from a single ADC lane.
    typedef logic signed [`CAP_ADC_BITS-1:0] adc_sample_t;

    // Every lane of one clock packed together with lane 0 in the low bits.
    typedef logic [`CAP_LANES*`CAP_ADC_BITS-1:0] mem_word_t;

    // address across the whole tiled memory.
    typedef logic [`CAP_SYS_ADDR_BITS-1:0] sys_addr_t;

    // address inside one tile.
    typedef logic [`CAP_TILE_ADDR_BITS-1:0] tile_addr_t;

endpackage

//--- design/capture_defines.svh
`ifndef CAPTURE_DEFINES_SVH
`define CAPTURE_DEFINES_SVH

// Width of one signed ADC sample.
`define CAP_ADC_BITS 8

// Lanes delivered per clock, also the samples held in one memory word.
`define CAP_LANES 4

// Address bits inside a single SRAM tile.
`define CAP_TILE_ADDR_BITS 4

// Number of SRAM tiles that make up the capture memory.
`define CAP_TILES 4

// Full capture address. Keep this equal to tile bits plus log2 of the tile count.
`define CAP_SYS_ADDR_BITS 6

`endif
